/* compile.f */
+incdir+include
design/adpll_cfg_pkg.sv
design/adpll_sig_pkg.sv
design/mesh_ctrl.sv
design/phase_detector.sv
design/loop_filter.sv
design/nco.sv
design/adpll_node.sv
design/adpll_mesh_top.sv
verification/tb_adpll_mesh.sv

/* verification/tb_adpll_mesh.sv */
`timescale 1ns/100ps
`default_nettype none

`include "adpll_defines.svh"

module tb_adpll_mesh;

    localparam int GEN_PERIOD    = (1 << `ADPLL_NCO_WIDTH) / `ADPLL_NCO_BIAS;
    localparam int DIV8_PERIOD   = 8 * GEN_PERIOD;
    localparam int REF_PERIOD    = 120;
    localparam int RESET_CYCLES  = 8;
    localparam int ACK_LIMIT     = 16;
    localparam int CFG_CYCLES    = 60 * 8;    // up to 60 exchanges
    localparam int IDLE_CYCLES   = 500;
    localparam int FREE_CYCLES   = 4 * (5 * GEN_PERIOD + 3 * DIV8_PERIOD);
    localparam int SETTLE_CYCLES = 8000;
    localparam int TRACK_CYCLES  = 2 * 9 * (REF_PERIOD + 8);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + CFG_CYCLES + IDLE_CYCLES + FREE_CYCLES
                                  + SETTLE_CYCLES + TRACK_CYCLES + 1000;

    logic        clk258_x;
    logic        rst_n_i;
    logic        cfg_req_i;
    logic        cfg_we_i;
    logic [3:0]  cfg_addr_i;
    logic [15:0] cfg_wdata_i;
    logic        cfg_ack_o;
    logic [15:0] cfg_rdata_o;
    logic        ref_i;
    logic [3:0]  gen_o;
    logic [3:0]  div8_o;

    logic [15:0] lfsr_state;
    logic        ref_run;      // reference generator on
    logic        ref_armed;    // aligned to node 11 div8
    int          ref_phase;
    int          cycle_count;

    adpll_mesh_top u_dut (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .cfg_req_i   (cfg_req_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_rdata_o (cfg_rdata_o),
        .ref_i       (ref_i),
        .gen_o       (gen_o),
        .div8_o      (div8_o)
    );

    initial
    begin
        clk258_x = 1'b0;
        forever #20 clk258_x = ~clk258_x;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(posedge clk258_x)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run("timeout, the tests did not finish within the cycle limit");
    end

    // square wave, first rising edge lined up with node 11 div8
    initial
    begin
        ref_i     = 1'b0;
        ref_armed = 1'b0;
        ref_phase = 0;
        forever
        begin
            @(posedge clk258_x);
            #5;
            if (!ref_run)
            begin
                ref_armed = 1'b0;
                ref_i     = 1'b0;
            end
            else if (!ref_armed)
            begin
                if (div8_o[0])
                begin
                    ref_armed = 1'b1;
                    ref_phase = 0;
                    ref_i     = 1'b1;
                end
            end
            else
            begin
                ref_phase = (ref_phase + 1) % REF_PERIOD;
                ref_i     = (ref_phase < REF_PERIOD / 2);
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk258_x);
        #5;    // drive and sample point
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_word(output logic [15:0] word);
        int i;
        word = '0;
        for (i = 0; i < 16; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            word       = {word[14:0], lfsr_state[0]};    // one step per bit
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual));
    endtask

    task automatic cfg_exchange(input logic we, input logic [3:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        cfg_we_i    = we;
        cfg_addr_i  = addr;
        cfg_wdata_i = wdata;
        cfg_req_i   = 1'b1;
        waited      = 0;
        while (!cfg_ack_o)
        begin
            next_cycle();
            waited++;
            if (waited > ACK_LIMIT)
                fail_run("register port never raised ack after req");
        end
        rdata     = cfg_rdata_o;
        cfg_req_i = 1'b0;
        waited    = 0;
        while (cfg_ack_o)
        begin
            next_cycle();
            waited++;
            if (waited > ACK_LIMIT)
                fail_run("register port kept ack high after req dropped");
        end
    endtask

    task automatic cfg_write(input logic [3:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        cfg_exchange(1'b1, addr, data, unused);
    endtask

    task automatic cfg_read(input logic [3:0] addr, output logic [15:0] data);
        cfg_exchange(1'b0, addr, 16'h0000, data);
    endtask

    function automatic logic probe(input int node, input logic use_gen);
        return use_gen ? gen_o[node] : div8_o[node];
    endfunction

    // cycles spanned by a number of rising-edge periods
    task automatic measure_cycles(input int node, input logic use_gen, input int periods,
                                  output int cycles);
        logic prev;
        logic cur;
        int   rises;
        int   waited;
        rises  = -1;
        cycles = 0;
        waited = 0;
        prev   = probe(node, use_gen);
        while (rises < periods)
        begin
            next_cycle();
            cur = probe(node, use_gen);
            if (rises >= 0)
                cycles++;
            if (cur && !prev)
                rises++;
            prev = cur;
            waited++;
            if (waited > 2 * DIV8_PERIOD * (periods + 1))
                fail_run($sformatf("node index %0d stopped producing clock edges", node));
        end
    endtask

    task automatic check_reset_state();
        logic [15:0] data;
        check_value("cfg_ack_o", 0, cfg_ack_o);
        check_value("cfg_rdata_o", 0, cfg_rdata_o);
        check_value("gen_o", 0, gen_o);
        check_value("div8_o", 0, div8_o);
        cfg_read(`ADPLL_ADDR_GAIN, data);
        check_value("gains after reset", 16'h0000, data);
        cfg_read(`ADPLL_ADDR_W11, data);
        check_value("weights_11 after reset", 16'h2011, data);    // left 2 right 1 below 1
        cfg_read(`ADPLL_ADDR_W12, data);
        check_value("weights_12 after reset", 16'h2002, data);
        cfg_read(`ADPLL_ADDR_W21, data);
        check_value("weights_21 after reset", 16'h0220, data);
        cfg_read(`ADPLL_ADDR_W22, data);
        check_value("weights_22 after reset", 16'h2200, data);
        cfg_read(`ADPLL_ADDR_CTRL, data);
        check_value("enable after reset", 16'h0000, data);
    endtask

    task automatic handshake_order();
        int i;
        check_value("cfg_ack_o before req", 0, cfg_ack_o);
        cfg_we_i    = 1'b0;
        cfg_addr_i  = `ADPLL_ADDR_W11;
        cfg_wdata_i = 16'h0000;
        cfg_req_i   = 1'b1;
        next_cycle();
        check_value("cfg_ack_o one edge after req", 0, cfg_ack_o);
        next_cycle();
        check_value("cfg_ack_o two edges after req", 1, cfg_ack_o);
        for (i = 0; i < 4; i++)
        begin
            check_value("cfg_rdata_o while ack high", 16'h2011, cfg_rdata_o);
            next_cycle();
            check_value("cfg_ack_o while req held", 1, cfg_ack_o);
        end
        cfg_req_i = 1'b0;
        next_cycle();
        check_value("cfg_ack_o one edge after req drop", 1, cfg_ack_o);
        next_cycle();
        check_value("cfg_ack_o two edges after req drop", 0, cfg_ack_o);
    endtask

    task automatic readback_registers();
        logic [15:0] expected [0:4];
        logic [15:0] word;
        logic [15:0] data;
        int          addr;
        // address 0 decodes as gains, 1 to 4 as weights
        for (addr = 0; addr < 5; addr++)
        begin
            random_word(word);
            expected[addr] = word;
            cfg_write(4'(addr), word);
        end
        for (addr = 0; addr < 5; addr++)
        begin
            cfg_read(4'(addr), data);
            check_value($sformatf("cfg_rdata_o at address %0d", addr), expected[addr], data);
        end
        random_word(word);
        cfg_write(4'd9, word | 16'h0001);    // enable bit set in case it leaks
        cfg_read(4'd9, data);
        check_value("cfg_rdata_o at unmapped address 9", 16'h0000, data);
        cfg_read(4'd15, data);
        check_value("cfg_rdata_o at unmapped address 15", 16'h0000, data);
        cfg_read(`ADPLL_ADDR_CTRL, data);
        check_value("enable after unmapped write", 16'h0000, data);
        for (addr = 0; addr < 5; addr++)
        begin
            cfg_read(4'(addr), data);
            check_value($sformatf("cfg_rdata_o at address %0d after unmapped write", addr),
                        expected[addr], data);
        end
    endtask

    task automatic idle_when_disabled();
        int i;
        cfg_write(`ADPLL_ADDR_CTRL, 16'h0000);
        for (i = 0; i < IDLE_CYCLES; i++)
        begin
            next_cycle();
            check_value("gen_o while disabled", 0, gen_o);
            check_value("div8_o while disabled", 0, div8_o);
        end
    endtask

    task automatic free_running_periods();
        int node;
        int cycles;
        cfg_write(`ADPLL_ADDR_GAIN, 16'h0000);
        cfg_write(`ADPLL_ADDR_CTRL, 16'h0001);
        for (node = 0; node < 4; node++)
        begin
            measure_cycles(node, 1'b1, 4, cycles);
            check_value($sformatf("gen_o[%0d] cycles over 4 periods", node),
                        4 * GEN_PERIOD, cycles);
            measure_cycles(node, 1'b0, 2, cycles);
            check_value($sformatf("div8_o[%0d] cycles over 2 periods", node),
                        2 * DIV8_PERIOD, cycles);
        end
    endtask

    task automatic track_reference();
        int cycles;
        cfg_write(`ADPLL_ADDR_CTRL, 16'h0000);
        cfg_write(`ADPLL_ADDR_GAIN, {8'd255, 8'd64});    // kp, ki
        cfg_write(`ADPLL_ADDR_W11, 16'h2000);             // 11 follows ref_i
        cfg_write(`ADPLL_ADDR_W12, 16'h2000);             // 12 follows 11
        cfg_write(`ADPLL_ADDR_W21, 16'h0200);             // 21 follows 11 from above
        cfg_write(`ADPLL_ADDR_W22, 16'h2000);             // 22 follows 21
        ref_run = 1'b1;
        cfg_write(`ADPLL_ADDR_CTRL, 16'h0001);
        repeat (SETTLE_CYCLES) next_cycle();
        measure_cycles(0, 1'b0, 8, cycles);
        if (cycles < 8 * (REF_PERIOD - 2) || cycles > 8 * (REF_PERIOD + 2))
            check_value("div8_o[0] cycles over 8 periods", 8 * REF_PERIOD, cycles);
        measure_cycles(3, 1'b0, 8, cycles);
        if (cycles < 8 * (REF_PERIOD - 4) || cycles > 8 * (REF_PERIOD + 4))
            check_value("div8_o[3] cycles over 8 periods", 8 * REF_PERIOD, cycles);
    endtask

    initial
    begin
        cycle_count = 0;
        rst_n_i     = 1'b0;
        cfg_req_i   = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = 4'd0;
        cfg_wdata_i = 16'h0000;
        ref_run     = 1'b0;
        lfsr_state  = 16'd84;
        repeat (RESET_CYCLES) @(posedge clk258_x);
        #5;
        rst_n_i = 1'b1;
        check_reset_state();
        handshake_order();
        readback_registers();
        idle_when_disabled();
        free_running_periods();
        track_reference();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* design/adpll_mesh_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "adpll_defines.svh"

module adpll_mesh_top
(
    input  wire                          clk258_x,
    input  wire                          rst_n_i,
    input  wire                          cfg_req_i,
    input  wire                          cfg_we_i,
    input  wire [`ADPLL_ADDR_WIDTH-1:0]  cfg_addr_i,
    input  wire [`ADPLL_DATA_WIDTH-1:0]  cfg_wdata_i,
    output logic                         cfg_ack_o,
    output logic [`ADPLL_DATA_WIDTH-1:0] cfg_rdata_o,
    input  wire                          ref_i,     // external reference, div8 rate
    output logic [3:0]                   gen_o,     // bit 0 node 11 .. bit 3 node 22
    output logic [3:0]                   div8_o
);
    adpll_cfg_pkg::gain_t     gains;
    adpll_cfg_pkg::weight_t   weights_11;
    adpll_cfg_pkg::weight_t   weights_12;
    adpll_cfg_pkg::weight_t   weights_21;
    adpll_cfg_pkg::weight_t   weights_22;
    logic                     enable;
    adpll_sig_pkg::pdet_err_t err_left_12;
    adpll_sig_pkg::pdet_err_t err_above_21;
    adpll_sig_pkg::pdet_err_t err_left_22;
    adpll_sig_pkg::pdet_err_t err_above_22;

    mesh_ctrl u_ctrl (
        .clk258_x     (clk258_x),
        .rst_n_i      (rst_n_i),
        .cfg_req_i    (cfg_req_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_ack_o    (cfg_ack_o),
        .cfg_rdata_o  (cfg_rdata_o),
        .gains_o      (gains),
        .weights_11_o (weights_11),
        .weights_12_o (weights_12),
        .weights_21_o (weights_21),
        .weights_22_o (weights_22),
        .enable_o     (enable)
    );

    // node 11 locks to ref_i, its upper input loops back
    adpll_node u_node_11 (
        .clk258_x (clk258_x), .rst_n_i (rst_n_i), .enable_i (enable),
        .ref_left_i (ref_i), .ref_above_i (div8_o[0]),
        .err_right_i (~err_left_12), .err_below_i (~err_above_21),
        .weights_i (weights_11), .gains_i (gains),
        .err_left_o (), .err_above_o (), .gen_o (gen_o[0]), .div8_o (div8_o[0])
    );

    adpll_node u_node_12 (
        .clk258_x (clk258_x), .rst_n_i (rst_n_i), .enable_i (enable),
        .ref_left_i (div8_o[0]), .ref_above_i (div8_o[1]),
        .err_right_i ('0), .err_below_i (~err_above_22),
        .weights_i (weights_12), .gains_i (gains),
        .err_left_o (err_left_12), .err_above_o (), .gen_o (gen_o[1]), .div8_o (div8_o[1])
    );

    adpll_node u_node_21 (
        .clk258_x (clk258_x), .rst_n_i (rst_n_i), .enable_i (enable),
        .ref_left_i (div8_o[2]), .ref_above_i (div8_o[0]),
        .err_right_i (~err_left_22), .err_below_i ('0),
        .weights_i (weights_21), .gains_i (gains),
        .err_left_o (), .err_above_o (err_above_21), .gen_o (gen_o[2]), .div8_o (div8_o[2])
    );

    adpll_node u_node_22 (
        .clk258_x (clk258_x), .rst_n_i (rst_n_i), .enable_i (enable),
        .ref_left_i (div8_o[2]), .ref_above_i (div8_o[1]),
        .err_right_i ('0), .err_below_i ('0),    // mesh corner
        .weights_i (weights_22), .gains_i (gains),
        .err_left_o (err_left_22), .err_above_o (err_above_22),
        .gen_o (gen_o[3]), .div8_o (div8_o[3])
    );

endmodule

`default_nettype wire

/* design/adpll_node.sv */
`timescale 1ns/100ps
`default_nettype none

module adpll_node
(
    input  wire                           clk258_x,
    input  wire                           rst_n_i,
    input  wire                           enable_i,
    input  wire                           ref_left_i,
    input  wire                           ref_above_i,
    input  wire adpll_sig_pkg::pdet_err_t err_right_i,
    input  wire adpll_sig_pkg::pdet_err_t err_below_i,
    input  wire adpll_cfg_pkg::weight_t   weights_i,
    input  wire adpll_cfg_pkg::gain_t     gains_i,
    output adpll_sig_pkg::pdet_err_t      err_left_o,
    output adpll_sig_pkg::pdet_err_t      err_above_o,
    output logic                          gen_o,
    output logic                          div8_o
);
    logic                     strobe;    // both detectors share the feedback edge
    adpll_sig_pkg::nco_ctrl_t ctrl;

    phase_detector u_pdet_left (
        .clk258_x (clk258_x),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .ref_i    (ref_left_i),
        .fb_i     (div8_o),
        .err_o    (err_left_o),
        .strobe_o (strobe)
    );

    phase_detector u_pdet_above (
        .clk258_x (clk258_x),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .ref_i    (ref_above_i),
        .fb_i     (div8_o),
        .err_o    (err_above_o),
        .strobe_o ()
    );

    loop_filter u_filter (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .enable_i    (enable_i),
        .strobe_i    (strobe),
        .err_left_i  (err_left_o),
        .err_above_i (err_above_o),
        .err_right_i (err_right_i),
        .err_below_i (err_below_i),
        .weights_i   (weights_i),
        .gains_i     (gains_i),
        .ctrl_o      (ctrl)
    );

    nco u_nco (
        .clk258_x (clk258_x),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .ctrl_i   (ctrl),
        .gen_o    (gen_o),
        .div8_o   (div8_o)
    );

endmodule

`default_nettype wire

/* design/nco.sv */
`timescale 1ns/100ps
`default_nettype none

`include "adpll_defines.svh"

module nco
(
    input  wire                           clk258_x,
    input  wire                           rst_n_i,
    input  wire                           enable_i,
    input  wire adpll_sig_pkg::nco_ctrl_t ctrl_i,
    output logic                          gen_o,
    output logic                          div8_o
);
    localparam logic signed [`ADPLL_NCO_WIDTH:0] BIAS = `ADPLL_NCO_BIAS;

    logic signed [`ADPLL_NCO_WIDTH:0]   freq;
    logic        [`ADPLL_NCO_WIDTH-1:0] acc_q;
    logic                               gen_q;
    logic        [1:0]                  edge_cnt_q;

    assign freq  = BIAS + ctrl_i;
    assign gen_o = acc_q[`ADPLL_NCO_WIDTH-1];    // accumulator msb

    always_ff @(posedge clk258_x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            acc_q      <= '0;
            gen_q      <= 1'b0;
            edge_cnt_q <= '0;
            div8_o     <= 1'b0;
        end
        else if (!enable_i)
        begin
            acc_q      <= '0;
            gen_q      <= 1'b0;
            edge_cnt_q <= '0;
            div8_o     <= 1'b0;
        end
        else
        begin
            acc_q <= acc_q + freq[`ADPLL_NCO_WIDTH-1:0];
            gen_q <= gen_o;
            if (gen_o && !gen_q)
            begin
                edge_cnt_q <= edge_cnt_q + 2'd1;
                if (edge_cnt_q == 2'd3)
                    div8_o <= ~div8_o;    // every fourth gen edge
            end
        end
    end

endmodule

`default_nettype wire

/* design/loop_filter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "adpll_defines.svh"

module loop_filter
(
    input  wire                           clk258_x,
    input  wire                           rst_n_i,
    input  wire                           enable_i,
    input  wire                           strobe_i,
    input  wire adpll_sig_pkg::pdet_err_t err_left_i,
    input  wire adpll_sig_pkg::pdet_err_t err_above_i,
    input  wire adpll_sig_pkg::pdet_err_t err_right_i,
    input  wire adpll_sig_pkg::pdet_err_t err_below_i,
    input  wire adpll_cfg_pkg::weight_t   weights_i,
    input  wire adpll_cfg_pkg::gain_t     gains_i,
    output adpll_sig_pkg::nco_ctrl_t      ctrl_o
);
    localparam int SUM_W  = `ADPLL_PDET_WIDTH + 7;    // 4-bit weights, four terms
    localparam int PROD_W = SUM_W + 9;                // times an 8-bit gain
    localparam int ACC_W  = PROD_W + 1;
    localparam logic signed [`ADPLL_INT_WIDTH-1:0] INT_MAX =
        {1'b0, {(`ADPLL_INT_WIDTH-1){1'b1}}};
    localparam logic signed [`ADPLL_INT_WIDTH-1:0] INT_MIN =
        {1'b1, {(`ADPLL_INT_WIDTH-1){1'b0}}};
    localparam adpll_sig_pkg::nco_ctrl_t CTRL_MAX = {1'b0, {(`ADPLL_CTRL_WIDTH-1){1'b1}}};
    localparam adpll_sig_pkg::nco_ctrl_t CTRL_MIN = {1'b1, {(`ADPLL_CTRL_WIDTH-1){1'b0}}};

    logic signed [SUM_W-1:0]            err_sum;
    logic signed [PROD_W-1:0]           p_prod;
    logic signed [PROD_W-1:0]           i_prod;
    logic signed [ACC_W-1:0]            integ_sum;
    logic signed [ACC_W-1:0]            ctrl_sum;
    logic signed [`ADPLL_INT_WIDTH-1:0] integ_q;
    logic signed [`ADPLL_INT_WIDTH-1:0] integ_nxt;
    adpll_sig_pkg::nco_ctrl_t           ctrl_nxt;

    always_comb
    begin
        err_sum = $signed({1'b0, weights_i.left}) * err_left_i
                + $signed({1'b0, weights_i.above}) * err_above_i
                + $signed({1'b0, weights_i.right}) * err_right_i
                + $signed({1'b0, weights_i.below}) * err_below_i;
        p_prod    = $signed({1'b0, gains_i.kp}) * err_sum;
        i_prod    = $signed({1'b0, gains_i.ki}) * err_sum;
        integ_sum = integ_q + i_prod;
        if (integ_sum > INT_MAX)
            integ_nxt = INT_MAX;
        else if (integ_sum < INT_MIN)
            integ_nxt = INT_MIN;
        else
            integ_nxt = integ_sum[`ADPLL_INT_WIDTH-1:0];
        ctrl_sum = (p_prod >>> `ADPLL_KP_FRAC) + (integ_nxt >>> `ADPLL_KI_FRAC);
        if (ctrl_sum > CTRL_MAX)
            ctrl_nxt = CTRL_MAX;
        else if (ctrl_sum < CTRL_MIN)
            ctrl_nxt = CTRL_MIN;
        else
            ctrl_nxt = ctrl_sum[`ADPLL_CTRL_WIDTH-1:0];
    end

    always_ff @(posedge clk258_x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            integ_q <= '0;
            ctrl_o  <= '0;
        end
        else if (!enable_i)
        begin
            integ_q <= '0;
            ctrl_o  <= '0;
        end
        else if (strobe_i)
        begin
            integ_q <= integ_nxt;
            ctrl_o  <= ctrl_nxt;    // one cycle behind the error
        end
    end

endmodule

`default_nettype wire

/* design/phase_detector.sv */
`timescale 1ns/100ps
`default_nettype none

`include "adpll_defines.svh"

module phase_detector
(
    input  wire                      clk258_x,
    input  wire                      rst_n_i,
    input  wire                      enable_i,
    input  wire                      ref_i,
    input  wire                      fb_i,
    output adpll_sig_pkg::pdet_err_t err_o,
    output logic                     strobe_o
);
    localparam int PERIOD  = 8 * (1 << `ADPLL_NCO_WIDTH) / `ADPLL_NCO_BIAS;  // nominal div8
    localparam int ERR_MAX = (1 << (`ADPLL_PDET_WIDTH - 1)) - 1;
    localparam int ERR_MIN = -(1 << (`ADPLL_PDET_WIDTH - 1));

    logic       ref_q;
    logic       fb_q;
    logic       ref_rise;
    logic       fb_rise;
    logic       ref_seen_q;    // reference edge since the last feedback edge
    logic [7:0] cnt_q;         // cycles since the last reference edge
    int         lag;

    assign ref_rise = ref_i & ~ref_q;
    assign fb_rise  = fb_i & ~fb_q;

    always_comb
    begin
        lag = ref_rise ? 0 : int'(cnt_q);
        if (!(ref_seen_q || ref_rise))
            lag = ERR_MIN;                  // no reference yet, feedback is early
        else if (lag >= PERIOD / 2)
            lag = lag - PERIOD;             // nearer the next reference edge
        if (lag > ERR_MAX)
            lag = ERR_MAX;
        else if (lag < ERR_MIN)
            lag = ERR_MIN;
    end

    always_ff @(posedge clk258_x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ref_q      <= 1'b0;
            fb_q       <= 1'b0;
            ref_seen_q <= 1'b0;
            cnt_q      <= '0;
            err_o      <= '0;
            strobe_o   <= 1'b0;
        end
        else if (!enable_i)
        begin
            ref_q      <= 1'b0;
            fb_q       <= 1'b0;
            ref_seen_q <= 1'b0;
            cnt_q      <= '0;
            err_o      <= '0;
            strobe_o   <= 1'b0;
        end
        else
        begin
            ref_q    <= ref_i;
            fb_q     <= fb_i;
            strobe_o <= fb_rise;
            if (ref_rise)
                cnt_q <= 8'd1;
            else if (cnt_q != 8'hff)
                cnt_q <= cnt_q + 8'd1;    // saturates
            if (fb_rise)
            begin
                err_o      <= adpll_sig_pkg::pdet_err_t'(lag);
                ref_seen_q <= 1'b0;
            end
            else if (ref_rise)
                ref_seen_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/mesh_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "adpll_defines.svh"

module mesh_ctrl
(
    input  wire                          clk258_x,
    input  wire                          rst_n_i,
    input  wire                          cfg_req_i,
    input  wire                          cfg_we_i,
    input  wire [`ADPLL_ADDR_WIDTH-1:0]  cfg_addr_i,
    input  wire [`ADPLL_DATA_WIDTH-1:0]  cfg_wdata_i,
    output logic                         cfg_ack_o,
    output logic [`ADPLL_DATA_WIDTH-1:0] cfg_rdata_o,
    output adpll_cfg_pkg::gain_t         gains_o,
    output adpll_cfg_pkg::weight_t       weights_11_o,
    output adpll_cfg_pkg::weight_t       weights_12_o,
    output adpll_cfg_pkg::weight_t       weights_21_o,
    output adpll_cfg_pkg::weight_t       weights_22_o,
    output logic                         enable_o
);
    logic                     req_q;
    logic                     accept;
    adpll_cfg_pkg::cfg_word_u wr_word;
    adpll_cfg_pkg::cfg_word_u rd_word;

    assign accept  = req_q & ~cfg_ack_o;    // second edge after req rises
    assign wr_word = cfg_wdata_i;

    // read view after any write in this cycle
    always_comb
    begin
        rd_word = '0;
        case (cfg_addr_i)
            `ADPLL_ADDR_GAIN: rd_word.gain   = cfg_we_i ? wr_word.gain : gains_o;
            `ADPLL_ADDR_W11:  rd_word.weight = cfg_we_i ? wr_word.weight : weights_11_o;
            `ADPLL_ADDR_W12:  rd_word.weight = cfg_we_i ? wr_word.weight : weights_12_o;
            `ADPLL_ADDR_W21:  rd_word.weight = cfg_we_i ? wr_word.weight : weights_21_o;
            `ADPLL_ADDR_W22:  rd_word.weight = cfg_we_i ? wr_word.weight : weights_22_o;
            `ADPLL_ADDR_CTRL: rd_word = {{(`ADPLL_DATA_WIDTH-1){1'b0}},
                                         cfg_we_i ? cfg_wdata_i[0] : enable_o};
            default:          rd_word = '0;    // unmapped
        endcase
    end

    always_ff @(posedge clk258_x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            req_q        <= 1'b0;
            cfg_ack_o    <= 1'b0;
            cfg_rdata_o  <= '0;
            gains_o      <= '0;
            weights_11_o <= '{left: 4'd2, above: 4'd0, right: 4'd1, below: 4'd1};
            weights_12_o <= '{left: 4'd2, above: 4'd0, right: 4'd0, below: 4'd2};
            weights_21_o <= '{left: 4'd0, above: 4'd2, right: 4'd2, below: 4'd0};
            weights_22_o <= '{left: 4'd2, above: 4'd2, right: 4'd0, below: 4'd0};
            enable_o     <= 1'b0;
        end
        else
        begin
            req_q     <= cfg_req_i;
            cfg_ack_o <= req_q;                 // falls two edges after req drops
            if (accept)
                cfg_rdata_o <= rd_word;
            else if (!req_q)
                cfg_rdata_o <= '0;
            if (accept && cfg_we_i)
            begin
                case (cfg_addr_i)
                    `ADPLL_ADDR_GAIN: gains_o      <= wr_word.gain;
                    `ADPLL_ADDR_W11:  weights_11_o <= wr_word.weight;
                    `ADPLL_ADDR_W12:  weights_12_o <= wr_word.weight;
                    `ADPLL_ADDR_W21:  weights_21_o <= wr_word.weight;
                    `ADPLL_ADDR_W22:  weights_22_o <= wr_word.weight;
                    `ADPLL_ADDR_CTRL: enable_o     <= cfg_wdata_i[0];
                    default:          ;
                endcase
            end
        end
    end

    ack_after_req: assert property (@(posedge clk258_x) disable iff (!rst_n_i)
        $rose(cfg_ack_o) |-> $past(cfg_req_i));

    // master keeps req up until it sees ack
    req_held: assert property (@(posedge clk258_x) disable iff (!rst_n_i)
        !cfg_ack_o && $past(cfg_req_i) |-> cfg_req_i);

endmodule

`default_nettype wire

/* design/adpll_sig_pkg.sv */
`default_nettype none

`include "adpll_defines.svh"

package adpll_sig_pkg;

    typedef logic signed [`ADPLL_PDET_WIDTH-1:0] pdet_err_t;   // cycles, + when ref leads
    typedef logic signed [`ADPLL_CTRL_WIDTH-1:0] nco_ctrl_t;   // offset on the bias word

endpackage

`default_nettype wire

/* design/adpll_cfg_pkg.sv */
`default_nettype none

package adpll_cfg_pkg;

    // loop gains, both unsigned
    typedef struct packed {
        logic [7:0] kp;
        logic [7:0] ki;
    } gain_t;

    // per-node error weights, one nibble per direction
    typedef struct packed {
        logic [3:0] left;
        logic [3:0] above;
        logic [3:0] right;
        logic [3:0] below;
    } weight_t;

    // one register word, read as gains or as weights by its address
    typedef union packed {
        gain_t   gain;
        weight_t weight;
    } cfg_word_u;

endpackage

`default_nettype wire

/* include/adpll_defines.svh */
`ifndef ADPLL_DEFINES_SVH
`define ADPLL_DEFINES_SVH

// phase error and oscillator widths
`define ADPLL_PDET_WIDTH   5
`define ADPLL_NCO_WIDTH    16
`define ADPLL_NCO_BIAS     4096    // gen period 16 cycles, div8 period 128
`define ADPLL_CTRL_WIDTH   12
`define ADPLL_INT_WIDTH    20
`define ADPLL_KP_FRAC      6
`define ADPLL_KI_FRAC      7

// register port
`define ADPLL_ADDR_WIDTH   4
`define ADPLL_DATA_WIDTH   16
`define ADPLL_ADDR_GAIN    4'd0
`define ADPLL_ADDR_W11     4'd1
`define ADPLL_ADDR_W12     4'd2
`define ADPLL_ADDR_W21     4'd3
`define ADPLL_ADDR_W22     4'd4
`define ADPLL_ADDR_CTRL    4'd5    // bit 0 is the mesh enable

`endif
